// ==== hdl/oled_pkg.sv ====
package oled_pkg;

    // Panel geometry
    localparam int DISPLAY_WIDTH  = 128;                        // Columns
    localparam int DISPLAY_HEIGHT = 64;                         // Rows
    localparam int PAGE_COUNT     = DISPLAY_HEIGHT / 8;         // 8-row pages
    localparam int FB_BYTES       = PAGE_COUNT * DISPLAY_WIDTH; // One byte per page column

    typedef logic [7:0] byte_t;

    // Address is page * 128 + column
    typedef logic [$clog2(FB_BYTES)-1:0] fb_addr_t;

    // SSD1309 command bytes
    localparam byte_t CMD_DISPLAY_OFF     = 8'hAE; // Sleep
    localparam byte_t CMD_ADDR_MODE       = 8'h20; // Followed by mode byte
    localparam byte_t ADDR_MODE_HORIZ     = 8'h00; // Column then page increment
    localparam byte_t CMD_CONTRAST        = 8'h81; // Followed by level byte
    localparam byte_t CONTRAST_LEVEL      = 8'h7F; // Mid scale
    localparam byte_t CMD_NORMAL_MODE     = 8'hA6; // Not inverted
    localparam byte_t CMD_DISPLAY_RAM     = 8'hA4; // Show RAM contents
    localparam byte_t CMD_CHARGE_PUMP     = 8'h8D; // Followed by enable byte
    localparam byte_t CHARGE_PUMP_ENABLE  = 8'h14; // Needed before display on
    localparam byte_t CMD_DISPLAY_ON      = 8'hAF;

    localparam int INIT_LEN = 10;

    // Power-on command list, sent with cmd low
    localparam byte_t INIT_CMDS [INIT_LEN] = '{
        CMD_DISPLAY_OFF,
        CMD_ADDR_MODE,
        ADDR_MODE_HORIZ,
        CMD_CONTRAST,
        CONTRAST_LEVEL,
        CMD_NORMAL_MODE,
        CMD_DISPLAY_RAM,
        CMD_CHARGE_PUMP,
        CHARGE_PUMP_ENABLE,
        CMD_DISPLAY_ON
    };

endpackage

// ==== hdl/oled_framebuffer.sv ====
`timescale 1ns/1ps

module oled_framebuffer import oled_pkg::*; (
    input  logic     clk,
    input  logic     fb_we,   // Host write strobe
    input  fb_addr_t fb_addr, // Host write address
    input  byte_t    fb_data, // One column of one page
    input  fb_addr_t rd_addr, // From sequencer
    output byte_t    rd_data  // Valid one cycle after rd_addr
);

    // Stored in panel order, byte n goes out n-th in a frame
    // Bit 0 is the top row of the page
    byte_t mem [FB_BYTES];

    // Host side
    // Writes accepted every cycle, no back-pressure
    always_ff @(posedge clk) begin
        if (fb_we) begin
            mem[fb_addr] <= fb_data;
        end
    end

    // Sequencer side, registered read
    // Same-address write in the same cycle gives the old byte
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== hdl/oled_sequencer.sv ====
`timescale 1ns/1ps

module oled_sequencer import oled_pkg::*; #(
    parameter int STARTUP_DELAY = 10_000_000, // Cycles per res phase
    parameter int FRAME_GAP     = 270_000     // Idle cycles between frames
) (
    input  logic     clk,
    input  logic     reset,
    output logic     res,      // Panel reset pin, active low
    output fb_addr_t rd_addr,  // Framebuffer read address
    input  byte_t    rd_data,
    output logic     tx_valid, // Byte offered to serializer
    output byte_t    tx_byte,
    output logic     tx_dc,    // 0 command, 1 data
    input  logic     tx_ready
);

    // Shared delay counter must hold the larger of both delays
    localparam int DLY_MAX = (STARTUP_DELAY > FRAME_GAP) ? STARTUP_DELAY : FRAME_GAP;
    localparam int DLY_W   = $clog2(DLY_MAX + 1);
    localparam int IDX_W   = $clog2(INIT_LEN);

    typedef enum logic [2:0] {
        PRE_RESET,  // res high after power up
        RESETTING,  // res low
        POST_RESET, // res high again before commands
        INIT,
        CLEAR,
        DRAW,
        FRAME_WAIT
    } state_t;

    state_t           state;
    logic [DLY_W-1:0] dly_cnt;
    logic [IDX_W-1:0] init_idx;
    fb_addr_t         byte_cnt;  // Byte index in clear and draw
    logic             sent;
    logic             startup_done;
    logic             gap_done;
    logic             last_byte;

    assign sent         = tx_valid & tx_ready;                  // Handshake this cycle
    assign startup_done = (dly_cnt == DLY_W'(STARTUP_DELAY - 1));
    assign gap_done     = (dly_cnt == DLY_W'(FRAME_GAP - 1));
    assign last_byte    = (byte_cnt == fb_addr_t'(FB_BYTES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= PRE_RESET;
            dly_cnt  <= '0;
            init_idx <= '0;
            byte_cnt <= '0;
            rd_addr  <= '0;          // First frame reads from 0
            res      <= 1'b1;
            tx_valid <= 1'b0;
        end else begin
            case (state)
                PRE_RESET: begin
                    dly_cnt <= dly_cnt + 1'b1;
                    if (startup_done) begin
                        dly_cnt <= '0;
                        res     <= 1'b0; // Pull panel into reset
                        state   <= RESETTING;
                    end
                end
                RESETTING: begin
                    dly_cnt <= dly_cnt + 1'b1;
                    if (startup_done) begin
                        dly_cnt <= '0;
                        res     <= 1'b1; // Release
                        state   <= POST_RESET;
                    end
                end
                POST_RESET: begin
                    dly_cnt <= dly_cnt + 1'b1;
                    if (startup_done) begin
                        dly_cnt  <= '0;
                        init_idx <= '0;
                        state    <= INIT;
                    end
                end
                INIT: begin
                    if (sent) begin
                        tx_valid <= 1'b0;
                        init_idx <= init_idx + 1'b1;
                        if (init_idx == IDX_W'(INIT_LEN - 1)) begin
                            byte_cnt <= '0;
                            state    <= CLEAR;
                        end
                    end else if (!tx_valid) begin
                        tx_valid <= 1'b1;
                        tx_byte  <= INIT_CMDS[init_idx];
                        tx_dc    <= 1'b0; // Command
                    end
                end
                CLEAR: begin
                    if (sent) begin
                        tx_valid <= 1'b0;
                        byte_cnt <= byte_cnt + 1'b1; // Wraps to 0 for draw
                        if (last_byte) begin
                            state <= DRAW;
                        end
                    end else if (!tx_valid) begin
                        tx_valid <= 1'b1;
                        tx_byte  <= '0;   // Blank pixels
                        tx_dc    <= 1'b1;
                    end
                end
                DRAW: begin
                    if (sent) begin
                        tx_valid <= 1'b0;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_byte) begin
                            dly_cnt <= '0;
                            state   <= FRAME_WAIT;
                        end
                    end else if (!tx_valid) begin
                        // rd_addr was set at the previous offer, so rd_data is settled
                        tx_valid <= 1'b1;
                        tx_byte  <= rd_data;
                        tx_dc    <= 1'b1;
                        rd_addr  <= rd_addr + 1'b1; // Prefetch next, wraps at frame end
                    end
                end
                FRAME_WAIT: begin
                    // Count only once the last byte has left the serializer
                    if (tx_ready) begin
                        dly_cnt <= dly_cnt + 1'b1;
                        if (gap_done) begin
                            dly_cnt <= '0;
                            state   <= DRAW;
                        end
                    end
                end
                default: state <= PRE_RESET;
            endcase
        end
    end

endmodule

// ==== hdl/spi_byte_tx.sv ====
`timescale 1ns/1ps

module spi_byte_tx import oled_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  tx_valid,
    input  byte_t tx_byte,
    input  logic  tx_dc,    // Becomes cmd for the whole byte
    output logic  tx_ready,
    output logic  sclk,     // Panel samples on rising edge
    output logic  sdin,     // MSB first
    output logic  cs,       // Active low
    output logic  cmd       // Low for command, high for pixel data
);

    logic       busy;
    logic [4:0] cnt;    // Counts 0 to 17 from acceptance
    logic [6:0] shreg;  // Bits still to send after the MSB
    logic       accept;

    assign tx_ready = ~busy;
    assign accept   = tx_valid & ~busy;

    // MSB goes to sdin straight from tx_byte at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= tx_byte[6:0];
        end else if (busy && cnt[0] && cnt < 5'd15) begin
            shreg <= {shreg[5:0], 1'b0}; // Next bit up to [6]
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
            cs   <= 1'b1;
            sclk <= 1'b0;
            sdin <= 1'b0;
            cmd  <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= '0;
            cs   <= 1'b0;       // Select panel
            sclk <= 1'b0;
            sdin <= tx_byte[7]; // First bit in its low phase
            cmd  <= tx_dc;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt < 5'd15) begin
                if (!cnt[0]) begin
                    sclk <= 1'b1;     // High phase with sdin held
                end else begin
                    sclk <= 1'b0;     // Low phase of next bit
                    sdin <= shreg[6];
                end
            end else if (cnt == 5'd15) begin
                cs   <= 1'b1;         // Forced deselect gap
                sclk <= 1'b0;
                sdin <= 1'b0;
            end else if (cnt == 5'd17) begin
                busy <= 1'b0;         // Ready 18 cycles after acceptance
            end
        end
    end

endmodule

// ==== hdl/ssd1309_driver.sv ====
`timescale 1ns/1ps

module ssd1309_driver import oled_pkg::*; #(
    parameter int STARTUP_DELAY = 10_000_000, // About 1/3 s at 27 MHz
    parameter int FRAME_GAP     = 270_000     // About 100 frames/s at 27 MHz
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     fb_we,   // Host framebuffer write
    input  fb_addr_t fb_addr,
    input  byte_t    fb_data,
    output logic     sclk,    // Panel d0
    output logic     sdin,    // Panel d1
    output logic     res,
    output logic     cmd,     // Panel dc
    output logic     cs
);

    fb_addr_t rd_addr;
    byte_t    rd_data;
    logic     tx_valid;
    byte_t    tx_byte;
    logic     tx_dc;
    logic     tx_ready;

    // Display RAM, keeps contents over reset
    oled_framebuffer u_framebuffer (
        .clk     (clk),
        .fb_we   (fb_we),
        .fb_addr (fb_addr),
        .fb_data (fb_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Power-up, init, clear and redraw control
    oled_sequencer #(
        .STARTUP_DELAY (STARTUP_DELAY),
        .FRAME_GAP     (FRAME_GAP)
    ) u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .res      (res),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte),
        .tx_dc    (tx_dc),
        .tx_ready (tx_ready)
    );

    spi_byte_tx u_spi_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte),
        .tx_dc    (tx_dc),
        .tx_ready (tx_ready),
        .sclk     (sclk),
        .sdin     (sdin),
        .cs       (cs),
        .cmd      (cmd)
    );

endmodule

// ==== test/ssd1309_asserts.sv ====
`timescale 1ns/1ps

module ssd1309_asserts (
    input logic clk,
    input logic reset,
    input logic sclk,
    input logic sdin,
    input logic cs,
    input logic cmd
);

    int fail_count = 0; // Failed assertions so far

    // Clock parked between bytes
    property sclk_idle_when_deselected;
        @(posedge clk) disable iff (reset)
            (cs && $past(cs)) |-> $stable(sclk);
    endproperty

    // Panel samples on the rising edge, data must not move in the high phase
    property sdin_held_while_sclk_high;
        @(posedge clk) disable iff (reset)
            sclk |-> $stable(sdin);
    endproperty

    // D/C line fixed for the whole byte
    property cmd_held_while_selected;
        @(posedge clk) disable iff (reset)
            (!cs && !$past(cs)) |-> $stable(cmd);
    endproperty

    assert property (sclk_idle_when_deselected) else begin
        fail_count++;
        $error("sclk toggled while cs was high");
    end

    assert property (sdin_held_while_sclk_high) else begin
        fail_count++;
        $error("sdin changed while sclk was high");
    end

    assert property (cmd_held_while_selected) else begin
        fail_count++;
        $error("cmd changed while cs was low");
    end

endmodule

// Watch the pins right at the serializer
bind spi_byte_tx ssd1309_asserts u_asserts (
    .clk   (clk),
    .reset (reset),
    .sclk  (sclk),
    .sdin  (sdin),
    .cs    (cs),
    .cmd   (cmd)
);

// ==== test/tb_ssd1309.sv ====
`timescale 1ns/1ps

module tb_ssd1309
    import oled_pkg::*;
();

    localparam int          STARTUP         = 20;          // Short res phases
    localparam int          GAP             = 50;          // Short frame gap
    localparam int          CLK_PERIOD      = 40;          // ns
    localparam int          RESET_CYCLES    = 16;
    localparam int          BYTE_CYCLES     = 18;          // Serializer cycles per byte
    localparam int          BYTE_TIMEOUT    = GAP + 200;   // Longest wait for one byte
    localparam int          MID_FRAME_BYTES = 100;         // Frame progress before reset
    localparam logic [31:0] SEED            = 32'h6203c09a;

    // Panel power-on list in datasheet order
    localparam byte_t EXP_INIT [10] = '{8'hAE, 8'h20, 8'h00, 8'h81, 8'h7F,
                                        8'hA6, 8'hA4, 8'h8D, 8'h14, 8'hAF};

    logic     clk;
    logic     reset;
    logic     fb_we;
    fb_addr_t fb_addr;
    byte_t    fb_data;
    logic     sclk;
    logic     sdin;
    logic     res;
    logic     cmd;
    logic     cs;

    byte_t      mirror [FB_BYTES]; // Copy of every host write
    logic [8:0] rx_q [$];          // Decoded bytes as {cmd, data}
    byte_t      rx_shift;
    int         rx_bits;
    int         mismatch_count = 0;
    int         failure_count  = 0;
    int         assert_count;

    ssd1309_driver #(
        .STARTUP_DELAY (STARTUP),
        .FRAME_GAP     (GAP)
    ) DUT (
        .clk     (clk),
        .reset   (reset),
        .fb_we   (fb_we),
        .fb_addr (fb_addr),
        .fb_data (fb_data),
        .sclk    (sclk),
        .sdin    (sdin),
        .res     (res),
        .cmd     (cmd),
        .cs      (cs)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Panel side decoder
    always @(posedge sclk or posedge cs) begin
        if (cs) begin
            rx_bits = 0; // Rising cs drops a partial byte
        end else begin
            rx_shift = {rx_shift[6:0], sdin}; // MSB first
            rx_bits++;
            if (rx_bits == 8) begin
                rx_q.push_back({cmd, rx_shift});
                rx_bits = 0;
            end
        end
    end

    task automatic report_failure(input string what);
        failure_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, sig, expected, actual);
        end
    endtask

    task automatic write_byte(input fb_addr_t addr, input byte_t data);
        @(posedge clk);
        #2;
        fb_we   = 1'b1;
        fb_addr = addr;
        fb_data = data;
        mirror[addr] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #2;
        fb_we = 1'b0;
    endtask

    task automatic fill_framebuffer();
        for (int a = 0; a < FB_BYTES; a++) begin
            write_byte(fb_addr_t'(a), byte_t'($urandom));
        end
        end_writes();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        assert (cs === 1'b1 && sclk === 1'b0) else
            report_failure("SPI bus not idle during reset");
        @(posedge clk);
        #2;
        reset = 1'b0;
        rx_q.delete(); // Bytes from before the reset
    endtask

    task automatic pop_byte(output logic [8:0] item, output bit ok);
        int waited;
        waited = 0;
        item   = '0;
        while (rx_q.size() == 0 && waited < BYTE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = (rx_q.size() != 0);
        assert (ok) else
            report_failure($sformatf("no SPI byte decoded within %0d cycles", BYTE_TIMEOUT));
        if (ok) begin
            item = rx_q.pop_front();
        end
    endtask

    // res pulse and wait, starting right after reset release
    task automatic verify_power_up();
        int high_cnt;
        int low_cnt;
        int cs_bad;
        int res_bad;
        high_cnt = 0;
        low_cnt  = 0;
        cs_bad   = 0;
        res_bad  = 0;
        @(negedge clk);
        while (res === 1'b1 && high_cnt < 4 * STARTUP) begin
            if (cs !== 1'b1) cs_bad++;
            high_cnt++;
            @(negedge clk);
        end
        while (res === 1'b0 && low_cnt < 4 * STARTUP) begin
            if (cs !== 1'b1) cs_bad++;
            low_cnt++;
            @(negedge clk);
        end
        check_value("res high cycles before reset pulse", STARTUP, high_cnt);
        check_value("res low cycles", STARTUP, low_cnt);
        repeat (STARTUP) begin // Post-reset wait with res back high
            if (cs !== 1'b1) cs_bad++;
            if (res !== 1'b1) res_bad++;
            @(negedge clk);
        end
        assert (cs_bad == 0) else report_failure("cs went low during power-up sequence");
        assert (res_bad == 0) else report_failure("res did not return high after reset pulse");
        assert (rx_q.size() == 0) else report_failure("bytes decoded during power-up sequence");
    endtask

    // Init command list
    task automatic expect_init_list();
        logic [8:0] item;
        bit         ok;
        for (int i = 0; i < INIT_LEN; i++) begin
            pop_byte(item, ok);
            if (!ok) return;
            check_value($sformatf("cmd for init byte %0d", i), 0, item[8]);
            check_value($sformatf("sdin init byte %0d", i), EXP_INIT[i], item[7:0]);
        end
    endtask

    // Clear pass of zero data bytes
    task automatic expect_clear_pass();
        logic [8:0] item;
        bit         ok;
        for (int i = 0; i < FB_BYTES; i++) begin
            pop_byte(item, ok);
            if (!ok) return;
            check_value($sformatf("cmd for clear byte %0d", i), 1, item[8]);
            check_value($sformatf("sdin clear byte %0d", i), 0, item[7:0]);
        end
    endtask

    // One whole frame against the mirror in address order
    task automatic compare_frame(input string label);
        logic [8:0] item;
        bit         ok;
        for (int i = 0; i < FB_BYTES; i++) begin
            pop_byte(item, ok);
            if (!ok) return;
            check_value($sformatf("cmd for %s byte %0d", label, i), 1, item[8]);
            check_value($sformatf("sdin %s byte %0d", label, i), mirror[i], item[7:0]);
        end
    endtask

    // Random pattern written from reset onward
    task automatic first_frame();
        compare_frame("first frame");
    endtask

    // Long run of cs high marks the gap between frames
    task automatic wait_frame_boundary(output bit found);
        int high_run;
        int waited;
        high_run = 0;
        waited   = 0;
        while (high_run < GAP && waited < FB_BYTES * 20 + 2 * GAP + 200) begin
            @(negedge clk);
            waited++;
            if (cs === 1'b1) high_run++;
            else high_run = 0;
        end
        found = (high_run >= GAP);
    endtask

    // Host writes during a frame show up in the next whole frame
    task automatic live_update();
        int       waited;
        bit       found;
        fb_addr_t addr;
        byte_t    data;
        waited = 0;
        while (rx_q.size() == 0 && waited < BYTE_TIMEOUT) begin // Next frame under way
            @(negedge clk);
            waited++;
        end
        assert (rx_q.size() != 0) else report_failure("no frame started after the first frame");
        repeat (16) begin
            addr = fb_addr_t'($urandom_range(FB_BYTES - 1));
            data = byte_t'($urandom);
            write_byte(addr, data);
        end
        end_writes();
        wait_frame_boundary(found);
        assert (found) else report_failure("no frame gap seen after the live update");
        if (!found) return;
        rx_q.delete(); // Rest of the frame that was running during the writes
        compare_frame("updated frame");
    endtask

    // Driver reset mid-frame keeps the RAM contents
    task automatic reset_mid_frame();
        int waited;
        waited = 0;
        while (rx_q.size() < MID_FRAME_BYTES &&
               waited < GAP + MID_FRAME_BYTES * 20 + BYTE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (rx_q.size() >= MID_FRAME_BYTES) else
            report_failure("frame did not progress before the mid-frame reset");
        apply_reset();
        verify_power_up();
        expect_init_list();
        expect_clear_pass();
        compare_frame("frame after reset");
    endtask

    // Serializer rate per byte plus both waits of each delay and some slack
    function automatic longint test_cycles(input int bytes, input int delays);
        return longint'(bytes) * BYTE_CYCLES + 2 * delays + bytes * 4 + 1000;
    endfunction

    initial begin : watchdog
        longint budget;
        budget = test_cycles(0, 3 * STARTUP + RESET_CYCLES)
               + test_cycles(INIT_LEN, 0)
               + test_cycles(FB_BYTES, 0)
               + test_cycles(FB_BYTES, 0)
               + test_cycles(3 * FB_BYTES, 2 * GAP)
               + test_cycles(MID_FRAME_BYTES + INIT_LEN + 2 * FB_BYTES,
                             GAP + 3 * STARTUP + RESET_CYCLES);
        #(budget * CLK_PERIOD);
        $display("Timeout: tests still running after %0d clock cycles", budget);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset   = 1'b1;
        fb_we   = 1'b0;
        fb_addr = '0;
        fb_data = '0;
        fork
            begin
                apply_reset();
                verify_power_up();
            end
            fill_framebuffer(); // Overlaps reset and power-up
        join
        expect_init_list();
        expect_clear_pass();
        first_frame();
        live_update();
        reset_mid_frame();
        assert_count = DUT.u_spi_tx.u_asserts.fail_count;
        $display("Errors: %0d mismatches, %0d other failures, %0d SPI protocol failures",
                 mismatch_count, failure_count, assert_count);
        if (mismatch_count + failure_count + assert_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/oled_pkg.sv
hdl/oled_framebuffer.sv
hdl/oled_sequencer.sv
hdl/spi_byte_tx.sv
hdl/ssd1309_driver.sv
test/ssd1309_asserts.sv
test/tb_ssd1309.sv

// ==== Bender.yml ====
package:
  name: ssd1309_driver

sources:
  - hdl/oled_pkg.sv
  - hdl/oled_framebuffer.sv
  - hdl/oled_sequencer.sv
  - hdl/spi_byte_tx.sv
  - hdl/ssd1309_driver.sv
  - target: test
    files:
      - test/ssd1309_asserts.sv
      - test/tb_ssd1309.sv
